//--- Makefile
# Verilator build and run of the video processor testbench
VERILATOR ?= verilator
TOP       ?= ppu_core_tb
FILELIST  ?= ppu_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | awk -v pass="$(PASS_MSG)" \
	  '{ print } $$0 == pass { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/ppu_core_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on the video memory strobes and the interrupt output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ppu_core_props (
  input logic               clk,
  input logic               reset,
  input logic               write,
  input ppu_pkg::reg_addr_e ain,
  input logic               vram_r,
  input logic               vram_w,
  input logic               nmi,
  input logic               entering_vblank
);

  int fail_count = 0;  // Failed assertions so far

  // One direction at a time on the memory bus
  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(vram_r && vram_w))
    else begin
      fail_count++;
      $error("vram_r and vram_w high in the same cycle");
    end

  // Memory write only from a CPU write to the data port
  write_source: assert property (@(posedge clk) disable iff (reset)
    vram_w |-> (write && ain == ppu_pkg::reg_data))
    else begin
      fail_count++;
      $error("vram_w without a data port write");
    end

  // Flag sets at the end of the pulse cycle, NMI follows it
  nmi_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(nmi) |-> $past(entering_vblank))
    else begin
      fail_count++;
      $error("nmi rose outside the cycle after entering_vblank");
    end

endmodule

bind ppu_core ppu_core_props props (
  .clk, .reset, .write, .ain, .vram_r, .vram_w, .nmi, .entering_vblank
);

//--- bench/ppu_core_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the video processor CPU side: clock, reset, video memory
// model, access tasks, reference model, compare process and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ppu_core_tb;

  localparam int LINE = 16;
  localparam int VIS = 4;
  localparam int VBL = 3;
  localparam int FRAME = LINE * (VIS + VBL + 2);  // 144 cycles
  localparam int TIMEOUT = (3 * FRAME + 2 * 250 + 200) * 40;  // Frames, accesses, margin

  logic clk = 1'b0;
  logic reset, read, write, nmi, vram_r, vram_w;
  ppu_pkg::reg_addr_e ain;
  ppu_pkg::byte_t din, dout, vram_dout;
  ppu_pkg::byte_t vram_din = '0;
  ppu_pkg::bus_addr_t vram_a;
  ppu_pkg::coord_t scanline, cycle, t_line, t_cycle;
  logic [2:0] fine_x_scroll, m_fx;
  ppu_pkg::byte_t vmem [0:16383];   // Video memory model
  ppu_pkg::byte_t m_mem [0:16383];  // Reference copy of the memory
  ppu_pkg::color_t m_pal [0:31];
  ppu_pkg::vaddr_t m_tmp, m_cur;
  ppu_pkg::toggle_e m_tog;
  ppu_pkg::byte_t m_buf;
  logic m_buf_ok, m_inc, m_nmi_en, m_gray, m_flag;
  integer seed;
  int errors = 0;
  string test_name;

  ppu_core #(.LINE_CYCLES(LINE), .VISIBLE_LINES(VIS), .VBLANK_LINES(VBL)) uut (
    .clk, .reset, .ain, .din, .read, .write, .vram_din, .dout, .nmi, .vram_r, .vram_w,
    .vram_a, .vram_dout, .scanline, .cycle, .fine_x_scroll
  );

  always #20 clk = ~clk;

  // Pattern over the whole 14-bit address
  function automatic ppu_pkg::byte_t fill_value(input int a);
    return ppu_pkg::byte_t'(a ^ (a >> 6) ^ 'h5A);
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16384; i++)
        vmem[i] <= fill_value(i);
    end else begin
      if (vram_w) vmem[vram_a] <= vram_dout;
      if (vram_r) vram_din <= vmem[vram_a];  // Answer in the following cycle
    end
  end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    end
  endtask

  // One register access, inputs change on the falling edge
  task automatic access(input ppu_pkg::reg_addr_e a, input ppu_pkg::byte_t d, input logic rd);
    @(negedge clk);
    ain = a;
    din = d;
    read = rd;
    write = !rd;
    @(negedge clk);
    read = 1'b0;
    write = 1'b0;
  endtask

  // Set the step and the address, then n data accesses
  task automatic data_run(input logic row, input ppu_pkg::byte_t hi, input ppu_pkg::byte_t lo,
                          input logic rd, input int n);
    access(ppu_pkg::reg_ctrl, row ? 8'h84 : 8'h80, 1'b0);  // NMI enable stays on
    access(ppu_pkg::reg_addr, hi, 1'b0);
    access(ppu_pkg::reg_addr, lo, 1'b0);
    repeat (n) access(ppu_pkg::reg_data, rd ? 8'h00 : ppu_pkg::byte_t'($random(seed)), rd);
  endtask

  // Reference model of one access, returns expected dout and address
  function automatic ppu_pkg::byte_t predict(input ppu_pkg::reg_addr_e a,
      input ppu_pkg::byte_t d, input logic rd, output ppu_pkg::bus_addr_t exp_a,
      output logic known);
    ppu_pkg::byte_t res;
    ppu_pkg::pal_idx_t idx;
    ppu_pkg::color_t c;
    res = '0;
    known = 1'b1;
    exp_a = m_cur[13:0];
    idx = m_cur[4:0];
    c = (idx[1:0] == 2'b00) ? m_pal[0] : m_pal[idx];  // Backdrop mirror
    case (a)
      ppu_pkg::reg_ctrl: begin
        m_tmp[11:10] = d[1:0];
        m_inc = d[2];
        m_nmi_en = d[7];
      end
      ppu_pkg::reg_mask: m_gray = d[0];
      ppu_pkg::reg_status: begin
        res = {m_flag, 7'b0};
        m_tog = ppu_pkg::first_write;
      end
      ppu_pkg::reg_scroll:
        if (m_tog == ppu_pkg::first_write) {m_tmp[4:0], m_fx} = d;
        else {m_tmp[9:5], m_tmp[14:12]} = d;
      ppu_pkg::reg_addr:
        if (m_tog == ppu_pkg::first_write) begin
          m_tmp[14:8] = {1'b0, d[5:0]};
        end else begin
          m_tmp[7:0] = d;
          m_cur = m_tmp;
        end
      ppu_pkg::reg_data: begin
        if (m_cur[13:8] != ppu_pkg::PAL_PAGE) begin
          if (rd) begin
            res = m_buf;  // Byte from the previous read
            known = m_buf_ok;
            m_buf = m_mem[m_cur[13:0]];
            m_buf_ok = 1'b1;
          end else begin
            m_mem[m_cur[13:0]] = d;
          end
        end else if (rd) begin
          res = {2'b00, c};
          if (m_gray) res[3:0] = 4'b0000;  // Grayscale keeps bits 5:4
        end else if (idx[1:0] != 2'b00) begin
          m_pal[idx] = d[5:0];
        end else if (idx == 5'd0 || idx == 5'd16) begin
          m_pal[0] = d[5:0];  // Other color-0 slots drop the write
        end
        m_cur = m_cur + (m_inc ? ppu_pkg::vaddr_t'(ppu_pkg::ROW_STEP) : ppu_pkg::vaddr_t'(1));
      end
      default: ;
    endcase
    if (a == ppu_pkg::reg_scroll || a == ppu_pkg::reg_addr)
      m_tog = (m_tog == ppu_pkg::first_write) ? ppu_pkg::second_write : ppu_pkg::first_write;
    return res;
  endfunction

  // Compare process, samples just before each rising edge takes effect
  always @(posedge clk) begin
    ppu_pkg::bus_addr_t exp_a;
    ppu_pkg::byte_t exp_d;
    logic known, pal, dat, ent, ext;
    if (reset) begin
      t_cycle = '0;
      t_line = '0;
      m_tmp = '0;
      m_cur = '0;
      m_fx = '0;
      m_tog = ppu_pkg::first_write;
      m_buf_ok = 1'b0;  // Nothing read yet
      m_inc = 1'b0;
      m_nmi_en = 1'b0;
      m_gray = 1'b0;
      m_flag = 1'b0;
      for (int i = 0; i < 16384; i++)
        m_mem[i] = fill_value(i);
    end else begin
      check_value("cycle", t_cycle, cycle);
      check_value("scanline", t_line, scanline);
      check_value("nmi", m_flag && m_nmi_en, nmi);
      check_value("fine_x", m_fx, fine_x_scroll);
      pal = (m_cur[13:8] == ppu_pkg::PAL_PAGE);
      dat = (ain == ppu_pkg::reg_data);
      check_value("vram_r", read && dat && !pal, vram_r);
      check_value("vram_w", write && dat && !pal, vram_w);
      ent = (t_cycle == LINE - 1) && (t_line == VIS);
      ext = (t_cycle == LINE - 1) && (t_line == VIS + VBL);
      if (read || write) begin
        exp_d = predict(ain, din, read, exp_a, known);
        if (dat) check_value("vram_a", exp_a, vram_a);
        if (read && known) check_value("dout", exp_d, dout);
        if (write && dat && !pal) check_value("vram_dout", din, vram_dout);
      end
      if (ext) m_flag = 1'b0;
      if (ent) m_flag = 1'b1;
      if (read && ain == ppu_pkg::reg_status) m_flag = 1'b0;  // Read wins over the set
      if (t_cycle == LINE - 1) begin
        t_cycle = '0;
        t_line = ext ? '1 : t_line + 1'b1;  // All ones is the pre-render line
      end else begin
        t_cycle = t_cycle + 1'b1;
      end
    end
  end

  initial begin
    seed = 32'h915fa28f;
    test_name = "reset";
    reset = 1'b1;
    ain = ppu_pkg::reg_ctrl;
    din = '0;
    read = 1'b0;
    write = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    test_name = "frame_timing";
    access(ppu_pkg::reg_ctrl, 8'h80, 1'b0);  // NMI on while the flag is clear
    while (!nmi) @(negedge clk);
    check_value("nmi rise line", VIS + 1, scanline);
    check_value("nmi rise cycle", 0, cycle);
    while (nmi) @(negedge clk);
    check_value("nmi fall line", 9'h1FF, scanline);
    check_value("nmi fall cycle", 0, cycle);
    test_name = "status_read";
    while (scanline != VIS + 1) @(negedge clk);
    access(ppu_pkg::reg_status, 8'h00, 1'b1);  // Flag set
    access(ppu_pkg::reg_status, 8'h00, 1'b1);  // Cleared by the first read
    test_name = "data_write";
    data_run(1'b0, 8'h21, 8'h08, 1'b0, 8);
    data_run(1'b1, 8'h24, 8'h08, 1'b0, 8);
    test_name = "buffered_read";
    data_run(1'b0, 8'h21, 8'h08, 1'b1, 9);
    data_run(1'b1, 8'h24, 8'h08, 1'b1, 9);  // First read gives the last byte above
    test_name = "palette";
    data_run(1'b0, 8'h3F, 8'h00, 1'b0, 32);  // Every slot written first
    for (int i = 0; i < 40; i++) begin
      if (i == 20) access(ppu_pkg::reg_mask, 8'h01, 1'b0);  // Grayscale on
      access(ppu_pkg::reg_addr, 8'h3F, 1'b0);
      access(ppu_pkg::reg_addr, ppu_pkg::byte_t'($random(seed) & 'h1F), 1'b0);
      access(ppu_pkg::reg_data, ppu_pkg::byte_t'($random(seed)), 1'($random(seed)));
    end
    test_name = "scroll_toggle";
    access(ppu_pkg::reg_scroll, ppu_pkg::byte_t'($random(seed)), 1'b0);
    access(ppu_pkg::reg_status, 8'h00, 1'b1);  // Toggle back to first write
    data_run(1'b0, 8'h22, 8'h33, 1'b0, 1);
    repeat (4) @(negedge clk);
    $display("Checks done, %0d check errors, %0d assertion failures", errors,
             uut.props.fail_count);
    if (errors == 0 && uut.props.fail_count == 0) $display("NO ERRORS");
    else $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: run did not finish in %0d time units, %0d errors", TIMEOUT, errors);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- ppu_core.f
src/ppu_pkg.sv
src/frame_timer.sv
src/ppu_regs.sv
src/scroll_addr.sv
src/vram_port.sv
src/palette_ram.sv
src/ppu_core.sv
bench/ppu_core_props.sv
bench/ppu_core_tb.sv

//--- src/frame_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Frame timer: cycle and scanline counters, vertical blank flag and
// the one-cycle pulses on entering and leaving the blank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module frame_timer #(
  parameter int LINE_CYCLES   = ppu_pkg::DEF_LINE_CYCLES,
  parameter int VISIBLE_LINES = ppu_pkg::DEF_VISIBLE_LINES,
  parameter int VBLANK_LINES  = ppu_pkg::DEF_VBLANK_LINES
) (
  input  logic            clk,
  input  logic            reset,
  output ppu_pkg::coord_t cycle,
  output ppu_pkg::coord_t scanline,
  output logic            in_vblank,
  output logic            entering_vblank,
  output logic            exiting_vblank
);

  // Line layout
  // 0 .. VISIBLE_LINES-1             picture
  // VISIBLE_LINES                    idle line, blank starts at its end
  // .. VISIBLE_LINES+VBLANK_LINES    blanking, ends at the last line's end
  // all ones                         pre-render line, then back to 0
  localparam ppu_pkg::coord_t LAST_CYCLE = ppu_pkg::coord_t'(LINE_CYCLES - 1);
  localparam ppu_pkg::coord_t BLANK_START = ppu_pkg::coord_t'(VISIBLE_LINES);
  localparam ppu_pkg::coord_t BLANK_END =
    ppu_pkg::coord_t'(VISIBLE_LINES + VBLANK_LINES);

  logic end_of_line;  // Last cycle of any line

  assign end_of_line     = (cycle == LAST_CYCLE);
  assign entering_vblank = end_of_line && (scanline == BLANK_START);
  assign exiting_vblank  = end_of_line && (scanline == BLANK_END);

  // Cycle within the line
  always_ff @(posedge clk) begin
    if (reset) begin
      cycle <= '0;
    end else begin
      cycle <= end_of_line ? '0 : cycle + 1'b1;
    end
  end

  // Scanline, the pre-render line wraps to 0 by plain overflow
  always_ff @(posedge clk) begin
    if (reset) begin
      scanline  <= '0;
      in_vblank <= 1'b1;  // Starts inside blank, as after power-up
    end else begin
      if (end_of_line) begin
        scanline <= exiting_vblank ? '1 : scanline + 1'b1;
      end
      if (entering_vblank) in_vblank <= 1'b1;
      else if (exiting_vblank) in_vblank <= 1'b0;
    end
  end

endmodule

//--- src/palette_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Palette RAM, 32 by 6, with shared backdrop and write masking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module palette_ram (
  input  logic               clk,
  input  ppu_pkg::pal_idx_t  pal_idx,
  input  ppu_pkg::color_t    din,
  input  logic               pal_write,
  output ppu_pkg::color_t    color
);

  ppu_pkg::color_t   mem [0:31];
  ppu_pkg::pal_idx_t eff_idx;   // Index after backdrop folding
  logic              wr_allow;

  // Every color-0 slot reads the common backdrop
  assign eff_idx = (pal_idx[1:0] == 2'b00) ? '0 : pal_idx;

  // Of the color-0 slots only 0 and 16 take writes
  assign wr_allow = !((pal_idx[3:2] != 2'b00) && (pal_idx[1:0] == 2'b00));

  assign color = mem[eff_idx];  // Asynchronous read

  always_ff @(posedge clk) begin
    if (pal_write && wr_allow) begin
      mem[eff_idx] <= din;  // 16 lands on entry 0
    end
  end

endmodule

//--- src/ppu_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video processor CPU side: timer, register decode, scroll and address
// unit, memory port and palette
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ppu_core #(
  parameter int LINE_CYCLES   = ppu_pkg::DEF_LINE_CYCLES,
  parameter int VISIBLE_LINES = ppu_pkg::DEF_VISIBLE_LINES,
  parameter int VBLANK_LINES  = ppu_pkg::DEF_VBLANK_LINES
) (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::reg_addr_e  ain,
  input  ppu_pkg::byte_t      din,
  input  logic                read,
  input  logic                write,
  input  ppu_pkg::byte_t      vram_din,
  output ppu_pkg::byte_t      dout,
  output logic                nmi,
  output logic                vram_r,
  output logic                vram_w,
  output ppu_pkg::bus_addr_t  vram_a,
  output ppu_pkg::byte_t      vram_dout,
  output ppu_pkg::coord_t     scanline,
  output ppu_pkg::coord_t     cycle,
  output logic [2:0]          fine_x_scroll
);

  logic entering_vblank, exiting_vblank;
  logic ctrl_write, scroll_write, addr_write, data_access;
  logic status_read, data_read, data_write;
  logic increment_row;
  logic in_pal, pal_write;
  ppu_pkg::vaddr_t   vaddr;
  ppu_pkg::pal_idx_t pal_idx;
  ppu_pkg::byte_t    buffered;
  ppu_pkg::color_t   color;

  frame_timer #(
    .LINE_CYCLES(LINE_CYCLES),
    .VISIBLE_LINES(VISIBLE_LINES),
    .VBLANK_LINES(VBLANK_LINES)
  ) timer (
    .clk, .reset, .cycle, .scanline, .in_vblank(), .entering_vblank, .exiting_vblank
  );

  ppu_regs regs (
    .clk, .reset, .ain, .din, .read, .write, .entering_vblank, .exiting_vblank,
    .in_pal, .buffered, .color, .dout, .nmi, .increment_row, .ctrl_write,
    .scroll_write, .addr_write, .data_access, .status_read, .data_read, .data_write
  );

  scroll_addr scroll (
    .clk, .reset, .din, .ctrl_write, .scroll_write, .addr_write, .data_access,
    .status_read, .increment_row, .vaddr, .fine_x_scroll
  );

  vram_port mem_port (
    .clk, .reset, .vaddr, .data_read, .data_write, .din, .vram_din, .vram_a,
    .vram_r, .vram_w, .vram_dout, .in_pal, .pal_write, .pal_idx, .buffered
  );

  // Palette sees only the low 6 bits of the CPU byte
  palette_ram palette (
    .clk, .pal_idx, .din(din[5:0]), .pal_write, .color
  );

endmodule

//--- src/ppu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the video processor register side: register numbers,
// write toggle, address and data widths, default frame timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ppu_pkg;

  // CPU-visible register numbers, 3 and 4 belong to sprite memory (not here)
  typedef enum logic [2:0] {
    reg_ctrl   = 3'd0,  // Control, increment step and NMI enable
    reg_mask   = 3'd1,  // Mask, only grayscale is kept
    reg_status = 3'd2,  // Status, vblank flag in bit 7
    reg_scroll = 3'd5,  // Scroll pair
    reg_addr   = 3'd6,  // Address pair
    reg_data   = 3'd7   // Data port
  } reg_addr_e;

  // Shared first/second write latch of scroll and address registers
  typedef enum logic {
    first_write  = 1'b0,
    second_write = 1'b1
  } toggle_e;

  typedef logic [14:0] vaddr_t;     // Internal address, bits 14:12 fine Y
  typedef logic [13:0] bus_addr_t;  // External video bus
  typedef logic [7:0]  byte_t;
  typedef logic [5:0]  color_t;     // Palette entry
  typedef logic [4:0]  pal_idx_t;   // 32 palette slots
  typedef logic [8:0]  coord_t;     // Cycle and scanline counters

  // Bits 13:8 of an address inside the palette range
  localparam logic [5:0] PAL_PAGE = 6'h3F;

  // Data port step when control bit 2 is set, one tile row
  localparam int ROW_STEP = 32;

  // Full-size frame
  localparam int DEF_LINE_CYCLES   = 341;
  localparam int DEF_VISIBLE_LINES = 240;
  localparam int DEF_VBLANK_LINES  = 20;

endpackage

//--- src/ppu_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register decode: access strobes, control and mask bits, vblank flag,
// NMI output and the CPU read-data mux
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module ppu_regs (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::reg_addr_e ain,
  input  ppu_pkg::byte_t     din,
  input  logic               read,
  input  logic               write,
  input  logic               entering_vblank,
  input  logic               exiting_vblank,
  input  logic               in_pal,    // Current address is in palette range
  input  ppu_pkg::byte_t     buffered,  // Read buffer from the memory port
  input  ppu_pkg::color_t    color,     // Palette entry at current address
  output ppu_pkg::byte_t     dout,
  output logic               nmi,
  output logic               increment_row,
  output logic               ctrl_write,
  output logic               scroll_write,
  output logic               addr_write,
  output logic               data_access,
  output logic               status_read,
  output logic               data_read,
  output logic               data_write
);

  logic nmi_enable;   // Control bit 7
  logic grayscale;    // Mask bit 0
  logic vblank_flag;  // Status bit 7

  // One strobe per register access
  assign ctrl_write   = write && (ain == ppu_pkg::reg_ctrl);
  assign scroll_write = write && (ain == ppu_pkg::reg_scroll);
  assign addr_write   = write && (ain == ppu_pkg::reg_addr);
  assign data_write   = write && (ain == ppu_pkg::reg_data);
  assign data_read    = read && (ain == ppu_pkg::reg_data);
  assign status_read  = read && (ain == ppu_pkg::reg_status);
  assign data_access  = data_read || data_write;  // Either one bumps the address

  always_ff @(posedge clk) begin
    if (reset) begin
      increment_row <= 1'b0;
      nmi_enable    <= 1'b0;
      grayscale     <= 1'b0;
      vblank_flag   <= 1'b0;
    end else begin
      if (ctrl_write) begin
        increment_row <= din[2];
        nmi_enable    <= din[7];
      end
      if (write && (ain == ppu_pkg::reg_mask)) grayscale <= din[0];
      // A status read in the same cycle as the set pulse wins
      if (exiting_vblank) vblank_flag <= 1'b0;
      if (entering_vblank) vblank_flag <= 1'b1;
      if (status_read) vblank_flag <= 1'b0;
    end
  end

  assign nmi = vblank_flag && nmi_enable;

  // Read mux, zero when no read is under way
  always_comb begin
    dout = '0;
    if (read) begin
      case (ain)
        ppu_pkg::reg_status: dout = {vblank_flag, 7'b0};
        ppu_pkg::reg_data:
          if (in_pal) dout = {2'b00, color[5:4], grayscale ? 4'b0 : color[3:0]};
          else        dout = buffered;  // Last latched memory byte
        default: dout = '0;
      endcase
    end
  end

endmodule

//--- src/scroll_addr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scroll and address pair: temporary and current address, fine X and
// the write toggle shared by both register pairs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module scroll_addr (
  input  logic             clk,
  input  logic             reset,
  input  ppu_pkg::byte_t   din,
  input  logic             ctrl_write,
  input  logic             scroll_write,
  input  logic             addr_write,
  input  logic             data_access,
  input  logic             status_read,
  input  logic             increment_row,  // Step by a row instead of 1
  output ppu_pkg::vaddr_t  vaddr,
  output logic [2:0]       fine_x_scroll
);

  // Address bit map
  // 14:12 fine Y, 11:10 name table, 9:5 coarse Y, 4:0 coarse X
  ppu_pkg::vaddr_t  tmp_addr;  // Loaded piecewise by the CPU
  ppu_pkg::vaddr_t  cur_addr;  // Used by the data port
  logic [2:0]       fine_x;
  ppu_pkg::toggle_e toggle;
  ppu_pkg::vaddr_t  step;

  assign step = increment_row ? ppu_pkg::vaddr_t'(ppu_pkg::ROW_STEP)
                              : ppu_pkg::vaddr_t'(1);

  always_ff @(posedge clk) begin
    if (reset) begin
      tmp_addr <= '0;
      cur_addr <= '0;
      fine_x   <= '0;
      toggle   <= ppu_pkg::first_write;
    end else begin
      // Name-table select from control bits 1:0
      if (ctrl_write) tmp_addr[11:10] <= din[1:0];

      if (scroll_write) begin
        if (toggle == ppu_pkg::first_write) begin
          tmp_addr[4:0] <= din[7:3];    // Coarse X
          fine_x        <= din[2:0];
        end else begin
          tmp_addr[9:5]   <= din[7:3];  // Coarse Y
          tmp_addr[14:12] <= din[2:0];  // Fine Y
        end
      end

      if (addr_write) begin
        if (toggle == ppu_pkg::first_write) begin
          tmp_addr[13:8] <= din[5:0];  // High byte, only 6 bits
          tmp_addr[14]   <= 1'b0;
        end else begin
          tmp_addr[7:0] <= din;
          cur_addr      <= {tmp_addr[14:8], din};  // Transfer on second write
        end
      end

      // Both pairs share the latch
      if (scroll_write || addr_write) begin
        toggle <= (toggle == ppu_pkg::first_write) ? ppu_pkg::second_write
                                                   : ppu_pkg::first_write;
      end
      if (status_read) toggle <= ppu_pkg::first_write;

      if (data_access) cur_addr <= cur_addr + step;
    end
  end

  assign vaddr         = cur_addr;
  assign fine_x_scroll = fine_x;

endmodule

//--- src/vram_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data port: palette-range decode, video memory strobes and the
// buffered read latch for the one-cycle memory latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module vram_port (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::vaddr_t     vaddr,
  input  logic                data_read,
  input  logic                data_write,
  input  ppu_pkg::byte_t      din,
  input  ppu_pkg::byte_t      vram_din,
  output ppu_pkg::bus_addr_t  vram_a,
  output logic                vram_r,
  output logic                vram_w,
  output ppu_pkg::byte_t      vram_dout,
  output logic                in_pal,
  output logic                pal_write,
  output ppu_pkg::pal_idx_t   pal_idx,
  output ppu_pkg::byte_t      buffered
);

  logic read_pending;  // Memory answers in the cycle after vram_r

  // 3F00-3FFF goes to the palette, mirrored every 32 bytes
  assign in_pal  = (vaddr[13:8] == ppu_pkg::PAL_PAGE);
  assign pal_idx = vaddr[4:0];

  assign vram_a    = vaddr[13:0];  // Bit 14 never leaves the chip
  assign vram_dout = din;
  assign vram_r    = data_read && !in_pal;
  assign vram_w    = data_write && !in_pal;
  assign pal_write = data_write && in_pal;

  always_ff @(posedge clk) begin
    if (reset) read_pending <= 1'b0;
    else read_pending <= vram_r;
  end

  // Buffer holds the byte until the next memory read lands
  always_ff @(posedge clk) begin
    if (read_pending) begin
      buffered <= vram_din;
    end
  end

endmodule
